/* flight_rate_ctrl.f */
+incdir+verif
source/drone_rate_pkg.sv
source/apb_gain_regs.sv
source/rate_cycle_ctrl.sv
source/axis_pid.sv
source/motor_mixer.sv
source/flight_rate_ctrl.sv
verif/flight_rate_ctrl_tb.sv

/* Bender.yml */
package:
  name: flight_rate_ctrl

sources:
  - files:
      - source/drone_rate_pkg.sv
      - source/apb_gain_regs.sv
      - source/rate_cycle_ctrl.sv
      - source/axis_pid.sv
      - source/motor_mixer.sv
      - source/flight_rate_ctrl.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/flight_rate_ctrl_tb.sv

/* verif/rate_tb_util.svh */
`ifndef RATE_TB_UTIL_SVH
`define RATE_TB_UTIL_SVH

// galois lfsr, one step per random bit
function automatic logic lfsr_step();
	logic lsb;
	lsb = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (lsb)
		lfsr_state = lfsr_state ^ 32'h8020_0003;
	return lsb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int k = 0; k < n; k++)
		v = {v[30:0], lfsr_step()};
	return v;
endfunction

// two's complement value of w random bits
function automatic int signed_rand(input int w);
	int v;
	v = int'(rand_bits(w));
	if (v >= (1 << (w - 1)))
		v = v - (1 << w);
	return v;
endfunction

// one apb transfer, setup phase then access phase
task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
	int n;
	@(negedge start_signal);
	psel = 1'b1;
	pwrite = write;
	paddr = addr;
	pwdata = wdata;
	penable = 1'b0;
	@(negedge start_signal);
	penable = 1'b1;
	for (n = 0; n < TIMEOUT; n++) begin
		@(posedge start_signal);
		if (pready)
			break;
	end
	if (n == TIMEOUT)
		stop_on_error("APB transfer never completed, pready stayed low");
	rdata = prdata;
	err = pslverr;
	@(negedge start_signal);
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
	logic [31:0] unused;
	apb_access(1'b1, addr, data, unused, err);
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
	apb_access(1'b0, addr, 32'h0, data, err);
endtask

// pid rule for one axis, advances the model state
function automatic int model_axis(input int a, input int tgt, input int act, input int ang);
	int e;
	int d_err;
	longint s;
	int p;
	int i;
	int d;
	int sum;
	int lo;
	int hi;
	e = tgt + ang - act;
	s = longint'(integ_mdl[a]) + longint'(e);
	if (s > 64'sh7fff_ffff)
		integ_mdl[a] = 32'sh7fff_ffff;
	else if (s < -64'sh8000_0000)
		integ_mdl[a] = 32'sh8000_0000;
	else
		integ_mdl[a] = int'(s);
	d_err = e - prev_mdl[a];
	prev_mdl[a] = e;
	p = (int'($signed(regs_mirror[a][0][15:0])) * e) >>> regs_mirror[a][0][19:16];
	i = (int'($signed(regs_mirror[a][1][15:0])) * integ_mdl[a]) >>> regs_mirror[a][1][19:16];
	d = (int'($signed(regs_mirror[a][2][15:0])) * d_err) >>> regs_mirror[a][2][19:16];
	sum = p + i + d;
	lo = int'($signed(regs_mirror[a][3][15:0]));
	hi = int'($signed(regs_mirror[a][3][31:16]));
	if (sum < lo)
		return lo;
	if (sum > hi)
		return hi;
	return sum;
endfunction

function automatic logic [15:0] sat_u16(input int v);
	if (v < 0)
		return 16'h0000;
	if (v > 65535)
		return 16'hffff;
	return v[15:0];
endfunction

// x-frame mix on integer deg/s
function automatic void model_mix(input logic [15:0] thr);
	int t;
	int r;
	int p;
	int y;
	t = int'(thr);
	r = exp_rate[0] >>> 4;
	p = exp_rate[1] >>> 4;
	y = exp_rate[2] >>> 4;
	exp_motor[0] = sat_u16(t + p + r - y);
	exp_motor[1] = sat_u16(t + p - r + y);
	exp_motor[2] = sat_u16(t - p - r - y);
	exp_motor[3] = sat_u16(t - p + r + y);
endfunction

`endif

/* verif/flight_rate_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module flight_rate_ctrl_tb;
	import drone_rate_pkg::*;

	localparam int TIMEOUT = 50;
	localparam int YAW = 2;

	logic start_signal;
	logic resetn;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic sample_req;
	rate_t [NUM_AXES-1:0] target;
	rate_t [NUM_AXES-1:0] actual;
	rate_t [NUM_AXES-1:0] angle_error;
	motor_t throttle;
	logic sample_ready;
	motor_t [NUM_MOTORS-1:0] motor;
	logic cycle_done;

	// register image and reference model state
	logic [31:0] regs_mirror [NUM_AXES][4];
	int integ_mdl [NUM_AXES];
	int prev_mdl [NUM_AXES];
	int exp_rate [NUM_AXES];
	logic [15:0] exp_motor [NUM_MOTORS];
	logic [31:0] lfsr_state;
	logic [4:0] accept_pipe;
	logic [7:0] bad_addr [5] = '{8'h02, 8'h1e, 8'h34, 8'h40, 8'hfc};

	flight_rate_ctrl u_flight_rate_ctrl (.*);

	`include "rate_tb_util.svh"

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else stop_on_error($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	initial begin
		start_signal = 1'b0;
		forever #20 start_signal = ~start_signal;
	end

	// request to cycle_done is four edges, busy window in between
	always @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			accept_pipe = '0;
		end else begin
			// apb slave has no wait states
			check_val("pready", pready, 1'b1);
			check_val("cycle_done", cycle_done, accept_pipe[4]);
			check_val("sample_ready", sample_ready, !(|accept_pipe[3:0]));
			accept_pipe = {accept_pipe[3:0], sample_req && sample_ready};
		end
	end

	task automatic randomize_inputs(input int w);
		for (int a = 0; a < NUM_AXES; a++) begin
			target[a] = 16'(signed_rand(w));
			actual[a] = 16'(signed_rand(w));
			angle_error[a] = 16'(signed_rand(w));
		end
		throttle = 16'(rand_bits(16));
	endtask

	// one control tick, request held for hold_extra cycles after acceptance
	task automatic run_cycle(input int hold_extra);
		int n;
		@(negedge start_signal);
		sample_req = 1'b1;
		for (n = 0; n < TIMEOUT; n++) begin
			@(posedge start_signal);
			if (sample_ready)
				break;
		end
		if (n == TIMEOUT)
			stop_on_error("request never accepted, sample_ready stayed low");
		for (int a = 0; a < NUM_AXES; a++)
			exp_rate[a] = model_axis(a, $signed(target[a]), $signed(actual[a]),
				(a == YAW) ? 0 : $signed(angle_error[a]));
		model_mix(throttle);
		// inputs while busy must not leak into the cycle
		repeat (hold_extra) begin
			@(negedge start_signal);
			randomize_inputs(16);
		end
		@(negedge start_signal);
		sample_req = 1'b0;
		for (n = 0; n < TIMEOUT; n++) begin
			if (cycle_done)
				break;
			@(negedge start_signal);
		end
		if (n == TIMEOUT)
			stop_on_error("cycle_done never arrived after an accepted request");
		for (int m = 0; m < NUM_MOTORS; m++)
			check_val($sformatf("motor[%0d]", m), motor[m], exp_motor[m]);
	endtask

	task automatic cfg_write(input int a, input int w, input logic [31:0] data);
		logic err;
		apb_write(8'(a * 16 + w * 4), data, err);
		check_val("pslverr", err, 1'b0);
		regs_mirror[a][w] = (w == 3) ? data : (data & 32'h000f_ffff);
	endtask

	task automatic clear_integrators();
		logic err;
		apb_write(8'h30, 32'h0, err);
		check_val("pslverr", err, 1'b0);
		for (int a = 0; a < NUM_AXES; a++)
			integ_mdl[a] = 0;
	endtask

	task automatic check_readback();
		logic [31:0] data;
		logic err;
		for (int a = 0; a < NUM_AXES; a++) begin
			for (int w = 0; w < 4; w++) begin
				apb_read(8'(a * 16 + w * 4), data, err);
				check_val("pslverr", err, 1'b0);
				check_val($sformatf("cfg[%0d] word %0d", a, w), data, regs_mirror[a][w]);
			end
		end
	endtask

	initial begin
		logic err;
		logic [31:0] data;
		resetn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		sample_req = 1'b0;
		target = '0;
		actual = '0;
		angle_error = '0;
		throttle = '0;
		lfsr_state = 32'hbc62_8938;
		for (int a = 0; a < NUM_AXES; a++) begin
			regs_mirror[a][0] = 32'h0004_0001;
			regs_mirror[a][1] = 32'h0004_0000;
			regs_mirror[a][2] = 32'h0004_0000;
			regs_mirror[a][3] = 32'h7fff_8000;
			integ_mdl[a] = 0;
			prev_mdl[a] = 0;
		end
		repeat (10) @(posedge start_signal);
		@(negedge start_signal);
		resetn = 1'b1;

		// state right after reset
		check_val("sample_ready", sample_ready, 1'b1);
		check_val("cycle_done", cycle_done, 1'b0);
		for (int m = 0; m < NUM_MOTORS; m++)
			check_val($sformatf("motor[%0d]", m), motor[m], 32'h0);
		check_readback();

		// default gains, proportional only
		for (int i = 0; i < 12; i++) begin
			randomize_inputs(16);
			run_cycle(i % 4);
		end

		// integral and derivative paths
		for (int a = 0; a < NUM_AXES; a++) begin
			cfg_write(a, 1, 32'h0006_0003 + a);
			cfg_write(a, 2, 32'h0003_fffe - a);
		end
		check_readback();
		for (int i = 0; i < 6; i++) begin
			randomize_inputs(12);
			run_cycle(0);
		end
		clear_integrators();
		for (int i = 0; i < 3; i++) begin
			randomize_inputs(12);
			run_cycle(1);
		end

		// +-20 deg/s limits against large errors
		for (int a = 0; a < NUM_AXES; a++) begin
			cfg_write(a, 2, 32'h0004_0000);
			cfg_write(a, 3, 32'h0140_fec0);
		end
		clear_integrators();
		target = {16'h9000, 16'h7000, 16'h7000};
		actual = '0;
		angle_error = '0;
		throttle = 16'hffff;
		run_cycle(0);
		check_val("motor[0]", motor[0], 32'hffff);
		throttle = 16'h0000;
		run_cycle(0);
		check_val("motor[2]", motor[2], 32'h0);
		throttle = 16'h8000;
		run_cycle(2);

		// accesses outside the register map
		foreach (bad_addr[k]) begin
			apb_write(bad_addr[k], 32'hffff_ffff, err);
			check_val("pslverr", err, 1'b1);
			apb_read(bad_addr[k], data, err);
			check_val("pslverr", err, 1'b1);
			check_val("prdata", data, 32'h0);
		end
		check_readback();
		randomize_inputs(16);
		run_cycle(0);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* source/flight_rate_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module flight_rate_ctrl (
	input  logic start_signal,
	input  logic resetn,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [drone_rate_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic sample_req,
	input  drone_rate_pkg::rate_t [drone_rate_pkg::NUM_AXES-1:0] target,
	input  drone_rate_pkg::rate_t [drone_rate_pkg::NUM_AXES-1:0] actual,
	input  drone_rate_pkg::rate_t [drone_rate_pkg::NUM_AXES-1:0] angle_error,
	input  drone_rate_pkg::motor_t throttle,
	output logic sample_ready,
	output drone_rate_pkg::motor_t [drone_rate_pkg::NUM_MOTORS-1:0] motor,
	output logic cycle_done
);
	import drone_rate_pkg::*;

	pid_cfg_t [NUM_AXES-1:0] cfg;
	axis_sample_t [NUM_AXES-1:0] sample;
	rate_t [NUM_AXES-1:0] axis_rate;
	logic [NUM_AXES-1:0] axis_done;
	logic integ_clear;
	logic start;
	logic all_done;
	motor_t throttle_q;

	apb_gain_regs u_apb_gain_regs (
		.start_signal (start_signal),
		.resetn       (resetn),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.cfg          (cfg),
		.integ_clear  (integ_clear)
	);

	rate_cycle_ctrl u_rate_cycle_ctrl (
		.start_signal (start_signal),
		.resetn       (resetn),
		.sample_req   (sample_req),
		.target       (target),
		.actual       (actual),
		.angle_error  (angle_error),
		.throttle     (throttle),
		.sample_ready (sample_ready),
		.start        (start),
		.sample       (sample),
		.axis_done    (axis_done),
		.all_done     (all_done),
		.throttle_q   (throttle_q)
	);

	// one engine per body axis, indexed by axis_e
	for (genvar a = 0; a < NUM_AXES; a++) begin : g_axis
		axis_pid u_axis_pid (
			.start_signal (start_signal),
			.resetn       (resetn),
			.start        (start),
			.integ_clear  (integ_clear),
			.sample       (sample[a]),
			.cfg          (cfg[a]),
			.rate_out     (axis_rate[a]),
			.done         (axis_done[a])
		);
	end

	motor_mixer u_motor_mixer (
		.start_signal (start_signal),
		.resetn       (resetn),
		.all_done     (all_done),
		.rate         (axis_rate),
		.throttle     (throttle_q),
		.motor        (motor),
		.cycle_done   (cycle_done)
	);

endmodule

`default_nettype wire

/* source/motor_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_mixer (
	input  logic start_signal,
	input  logic resetn,
	input  logic all_done,
	input  drone_rate_pkg::rate_t [drone_rate_pkg::NUM_AXES-1:0] rate,
	input  drone_rate_pkg::motor_t throttle,
	output drone_rate_pkg::motor_t [drone_rate_pkg::NUM_MOTORS-1:0] motor,
	output logic cycle_done
);
	import drone_rate_pkg::*;

	logic signed [31:0] thr;
	logic signed [31:0] roll;
	logic signed [31:0] pitch;
	logic signed [31:0] yaw;
	logic signed [31:0] mix [NUM_MOTORS];

	function automatic motor_t sat_motor(input logic signed [31:0] v);
		if (v < 0)
			return '0;
		else if (v > 32'sd65535)
			return 16'hffff;
		else
			return v[15:0];
	endfunction

	// integer deg/s, fraction dropped
	assign thr   = $signed({16'h0000, throttle});
	assign roll  = 32'($signed(rate[AXIS_ROLL])) >>> 4;
	assign pitch = 32'($signed(rate[AXIS_PITCH])) >>> 4;
	assign yaw   = 32'($signed(rate[AXIS_YAW])) >>> 4;

	// motor order: front-left, front-right, rear-right, rear-left
	assign mix[0] = thr + pitch + roll - yaw;
	assign mix[1] = thr + pitch - roll + yaw;
	assign mix[2] = thr - pitch - roll - yaw;
	assign mix[3] = thr - pitch + roll + yaw;

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			motor      <= '0;
			cycle_done <= 1'b0;
		end else begin
			cycle_done <= all_done;
			// commands hold between cycles
			if (all_done) begin
				for (int m = 0; m < NUM_MOTORS; m++)
					motor[m] <= sat_motor(mix[m]);
			end
		end
	end

endmodule

`default_nettype wire

/* source/axis_pid.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_pid (
	input  logic start_signal,
	input  logic resetn,
	input  logic start,
	input  logic integ_clear,
	input  drone_rate_pkg::axis_sample_t sample,
	input  drone_rate_pkg::pid_cfg_t cfg,
	output drone_rate_pkg::rate_t rate_out,
	output logic done
);
	import drone_rate_pkg::*;

	localparam logic signed [31:0] INTEG_MAX = 32'sh7fff_ffff;
	localparam logic signed [31:0] INTEG_MIN = 32'sh8000_0000;

	// stage one
	logic signed [31:0] err;
	logic signed [31:0] integ_base;
	logic signed [32:0] integ_sum;
	logic signed [31:0] integ_next;
	logic signed [31:0] integ_q;
	logic signed [31:0] prev_err;
	logic signed [31:0] err_q;
	logic signed [31:0] derr_q;
	logic stage1_vld;

	// stage two
	logic signed [31:0] p_term;
	logic signed [31:0] i_term;
	logic signed [31:0] d_term;
	logic signed [31:0] pid_sum;
	rate_t clamped;

	assign err = 32'(sample.target) + 32'(sample.angle_error) - 32'(sample.actual);

	// a clear arriving with start still lets this sample accumulate from zero
	assign integ_base = integ_clear ? '0 : integ_q;
	assign integ_sum  = 33'(integ_base) + 33'(err);

	always_comb begin
		if (integ_sum[32] != integ_sum[31])
			integ_next = integ_sum[32] ? INTEG_MIN : INTEG_MAX;
		else
			integ_next = integ_sum[31:0];
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			integ_q    <= '0;
			prev_err   <= '0;
			stage1_vld <= 1'b0;
		end else begin
			stage1_vld <= start;
			if (start) begin
				integ_q  <= integ_next;
				prev_err <= err;
			end else if (integ_clear) begin
				integ_q <= '0;
			end
		end
	end

	always_ff @(posedge start_signal) begin
		if (start) begin
			err_q  <= err;
			derr_q <= err - prev_err;
		end
	end

	// products wrap at 32 bits before the shift
	assign p_term  = (cfg.k_p * err_q) >>> cfg.p_shift;
	assign i_term  = (cfg.k_i * integ_q) >>> cfg.i_shift;
	assign d_term  = (cfg.k_d * derr_q) >>> cfg.d_shift;
	assign pid_sum = p_term + i_term + d_term;

	always_comb begin
		if (pid_sum < 32'(cfg.rate_min))
			clamped = cfg.rate_min;
		else if (pid_sum > 32'(cfg.rate_max))
			clamped = cfg.rate_max;
		else
			clamped = pid_sum[15:0];
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn)
			done <= 1'b0;
		else
			done <= stage1_vld;
	end

	always_ff @(posedge start_signal) begin
		if (stage1_vld)
			rate_out <= clamped;
	end

endmodule

`default_nettype wire

/* source/rate_cycle_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rate_cycle_ctrl (
	input  logic start_signal,
	input  logic resetn,
	input  logic sample_req,
	input  drone_rate_pkg::rate_t [drone_rate_pkg::NUM_AXES-1:0] target,
	input  drone_rate_pkg::rate_t [drone_rate_pkg::NUM_AXES-1:0] actual,
	input  drone_rate_pkg::rate_t [drone_rate_pkg::NUM_AXES-1:0] angle_error,
	input  drone_rate_pkg::motor_t throttle,
	output logic sample_ready,
	output logic start,
	output drone_rate_pkg::axis_sample_t [drone_rate_pkg::NUM_AXES-1:0] sample,
	input  logic [drone_rate_pkg::NUM_AXES-1:0] axis_done,
	output logic all_done,
	output drone_rate_pkg::motor_t throttle_q
);
	import drone_rate_pkg::*;

	cycle_state_e state;
	cycle_state_e next_state;
	logic accept;

	assign sample_ready = (state == ST_WAITING);
	assign accept       = sample_ready && sample_req;

	// every engine reports in the same cycle, so the AND is a single pulse
	assign all_done = (state == ST_COMPLETE) && (&axis_done);

	always_comb begin
		next_state = state;
		case (state)
			ST_WAITING: begin
				if (sample_req)
					next_state = ST_STARTING;
			end
			ST_STARTING: begin
				next_state = ST_ACTIVE;
			end
			ST_ACTIVE: begin
				// engines take the start pulse into stage one
				if (!start)
					next_state = ST_COMPLETE;
			end
			ST_COMPLETE: begin
				// hold until every axis reports its clamped rate
				if (&axis_done)
					next_state = ST_WAITING;
			end
			default: begin
				next_state = ST_WAITING;
			end
		endcase
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			state <= ST_WAITING;
			start <= 1'b0;
		end else begin
			state <= next_state;
			start <= (state == ST_STARTING);
		end
	end

	// sample latch, held for the whole cycle
	always_ff @(posedge start_signal) begin
		if (accept) begin
			for (int a = 0; a < NUM_AXES; a++) begin
				sample[a].target <= target[a];
				sample[a].actual <= actual[a];
				// yaw has no angle loop above it
				if (axis_e'(a) == AXIS_YAW)
					sample[a].angle_error <= '0;
				else
					sample[a].angle_error <= angle_error[a];
			end
			throttle_q <= throttle;
		end
	end

endmodule

`default_nettype wire

/* source/apb_gain_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_gain_regs (
	input  logic start_signal,
	input  logic resetn,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [drone_rate_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output drone_rate_pkg::pid_cfg_t [drone_rate_pkg::NUM_AXES-1:0] cfg,
	output logic integ_clear
);
	import drone_rate_pkg::*;

	logic access;
	logic in_axis;
	logic is_clr;
	logic addr_ok;
	logic [APB_ADDR_W-1:0] axis_idx;
	logic [APB_ADDR_W-1:0] word_ofs;
	logic [1:0] sel;

	assign access   = psel && penable;
	assign axis_idx = paddr / AXIS_STRIDE;
	assign word_ofs = paddr % AXIS_STRIDE;
	assign sel      = axis_idx[1:0];
	assign is_clr   = (paddr == REG_INTEG_CLR);

	// four aligned words per axis, nothing else inside the stride
	always_comb begin
		in_axis = 1'b0;
		if (axis_idx < NUM_AXES) begin
			case (word_ofs)
				REG_GAIN_P, REG_GAIN_I, REG_GAIN_D, REG_LIMITS: in_axis = 1'b1;
				default: in_axis = 1'b0;
			endcase
		end
	end

	assign addr_ok = in_axis || is_clr;

	// zero wait states
	assign pready  = 1'b1;
	assign pslverr = access && !addr_ok;

	// readback, clear register reads as zero
	always_comb begin
		prdata = '0;
		if (in_axis) begin
			case (word_ofs)
				REG_GAIN_P: prdata = {12'h000, cfg[sel].p_shift, cfg[sel].k_p};
				REG_GAIN_I: prdata = {12'h000, cfg[sel].i_shift, cfg[sel].k_i};
				REG_GAIN_D: prdata = {12'h000, cfg[sel].d_shift, cfg[sel].k_d};
				REG_LIMITS: prdata = {cfg[sel].rate_max, cfg[sel].rate_min};
				default:    prdata = '0;
			endcase
		end
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			cfg         <= {NUM_AXES{DEF_PID_CFG}};
			integ_clear <= 1'b0;
		end else begin
			// one cycle strobe per write to the clear register
			integ_clear <= access && pwrite && is_clr;
			if (access && pwrite && in_axis) begin
				case (word_ofs)
					REG_GAIN_P: begin
						cfg[sel].k_p     <= pwdata[15:0];
						cfg[sel].p_shift <= pwdata[19:16];
					end
					REG_GAIN_I: begin
						cfg[sel].k_i     <= pwdata[15:0];
						cfg[sel].i_shift <= pwdata[19:16];
					end
					REG_GAIN_D: begin
						cfg[sel].k_d     <= pwdata[15:0];
						cfg[sel].d_shift <= pwdata[19:16];
					end
					REG_LIMITS: begin
						cfg[sel].rate_min <= pwdata[15:0];
						cfg[sel].rate_max <= pwdata[31:16];
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* source/drone_rate_pkg.sv */
`default_nettype none

package drone_rate_pkg;

	// airframe constants
	localparam int NUM_AXES   = 3;
	localparam int NUM_MOTORS = 4;
	localparam int APB_ADDR_W = 8;

	// signed 12.4 fixed point, deg/s
	typedef logic signed [15:0] rate_t;
	// unsigned motor command
	typedef logic [15:0] motor_t;
	// arithmetic right shift applied after a gain product
	typedef logic [3:0] shift_t;

	typedef enum logic [1:0] {
		AXIS_ROLL,
		AXIS_PITCH,
		AXIS_YAW
	} axis_e;

	typedef enum logic [1:0] {
		ST_WAITING,
		ST_STARTING,
		ST_ACTIVE,
		ST_COMPLETE
	} cycle_state_e;

	// one axis worth of latched inputs
	typedef struct packed {
		rate_t target;
		rate_t actual;
		rate_t angle_error;
	} axis_sample_t;

	// per-axis gains and output limits
	typedef struct packed {
		logic signed [15:0] k_p;
		logic signed [15:0] k_i;
		logic signed [15:0] k_d;
		shift_t p_shift;
		shift_t i_shift;
		shift_t d_shift;
		rate_t rate_min;
		rate_t rate_max;
	} pid_cfg_t;

	// reset values, pure proportional with full range
	localparam logic signed [15:0] DEF_K_P = 16'sd1;
	localparam logic signed [15:0] DEF_K_I = 16'sd0;
	localparam logic signed [15:0] DEF_K_D = 16'sd0;
	localparam shift_t DEF_SHIFT = 4'd4;
	localparam rate_t DEF_RATE_MIN = 16'sh8000;
	localparam rate_t DEF_RATE_MAX = 16'sh7fff;

	localparam pid_cfg_t DEF_PID_CFG = '{
		k_p:      DEF_K_P,
		k_i:      DEF_K_I,
		k_d:      DEF_K_D,
		p_shift:  DEF_SHIFT,
		i_shift:  DEF_SHIFT,
		d_shift:  DEF_SHIFT,
		rate_min: DEF_RATE_MIN,
		rate_max: DEF_RATE_MAX
	};

	// register map, byte addresses
	localparam logic [APB_ADDR_W-1:0] AXIS_STRIDE   = 8'h10;
	localparam logic [APB_ADDR_W-1:0] REG_GAIN_P    = 8'h00;
	localparam logic [APB_ADDR_W-1:0] REG_GAIN_I    = 8'h04;
	localparam logic [APB_ADDR_W-1:0] REG_GAIN_D    = 8'h08;
	localparam logic [APB_ADDR_W-1:0] REG_LIMITS    = 8'h0c;
	localparam logic [APB_ADDR_W-1:0] REG_INTEG_CLR = 8'h30;

endpackage

`default_nettype wire
